// ==== Makefile ====
TOP := titleScreenTb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/screenDraw_cfg.svh ====
`ifndef SCREEN_DRAW_CFG_SVH
`define SCREEN_DRAW_CFG_SVH

// Visible screen size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// Coordinate widths, wide enough for the screen size
`define X_BITS 8
`define Y_BITS 7

// Log2 of the tile edge, so tiles are 4x4
`define TILE_BITS 2

// Colour depth for the VGA adapter
`define COLOUR_BITS 3

// Three titles plus two animation frames
`define IMAGE_COUNT 5

// Clocks between screen starts, longer than one unstalled scan
`define FRAME_TICK_CYCLES 24000

`endif

// ==== common/screenPkg.sv ====
`include "screenDraw_cfg.svh"

package screenPkg;

	// Coordinate view of a pixel address
	// y sits above x so the flat word counts in raster order
	typedef struct packed {
		logic [`Y_BITS-1:0] y;
		logic [`X_BITS-1:0] x;
	} pixelCoordT;

	// Same 15 bits read as one word or as coordinates
	// Flat view for origin and end checks
	typedef union packed {
		logic [`Y_BITS+`X_BITS-1:0] flat;
		pixelCoordT coord;
	} pixelAddrT;

	// Images held in the tile memory, in ROM order
	typedef enum logic [2:0] {
		title1,
		title2,
		title3,
		catDog1,
		catDog2
	} imageT;

	// Sequencer states
	// load is a single cycle, draw covers the scan, hold waits for the tick
	typedef enum logic [1:0] {
		load,
		draw,
		hold
	} seqStateT;

endpackage

// ==== files.f ====
+incdir+common
common/screenPkg.sv
sequencer/screenSequencer.sv
scanner/pixelScanner.sv
logic/frameTicker.sv
logic/tileRom.sv
logic/titleScreenTop.sv
tb/titleScreen_assertions.sv
tb/titleScreenTb.sv

// ==== logic/frameTicker.sv ====
`include "screenDraw_cfg.svh"

module frameTicker (
	input  logic clk,
	input  logic reset,
	input  logic scanStart,
	output logic frameDue
);

	localparam int countBits = $clog2(`FRAME_TICK_CYCLES);

	// Counter is zero one cycle after scanStart, so flag on N-2
	localparam logic [countBits-1:0] tickLast = countBits'(`FRAME_TICK_CYCLES - 2);

	// Cycles since the last screen start
	logic [countBits-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			frameDue <= 1'b0;
		end else if (scanStart) begin
			// New screen, start timing again
			count <= '0;
			frameDue <= 1'b0;
		end else if (!frameDue) begin
			// Stops counting once due, flag sticks until next start
			count <= count + 1'b1;
			if (count == tickLast) begin
				frameDue <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/tileRom.sv ====
`include "screenDraw_cfg.svh"

module tileRom (
	input  screenPkg::imageT imageSel,
	input  screenPkg::pixelAddrT pixelAddr,
	output logic [`COLOUR_BITS-1:0] colour
);

	// Cells in one tile and entries over all images
	localparam int tileCells = 1 << (2 * `TILE_BITS);
	localparam int romDepth = `IMAGE_COUNT * tileCells;
	localparam int indexBits = $bits(screenPkg::imageT) + 2 * `TILE_BITS;

	// One tile of colours per image
	logic [`COLOUR_BITS-1:0] rom [romDepth];

	// Image, then row in tile, then column in tile
	logic [indexBits-1:0] index;

	initial begin
		$readmemh("logic/tiles.mem", rom);
	end

	// Low coordinate bits repeat the tile across the screen
	assign index = {imageSel,
		pixelAddr.coord.y[`TILE_BITS-1:0],
		pixelAddr.coord.x[`TILE_BITS-1:0]};

	// No clock, colour follows the address
	assign colour = rom[index];

endmodule

// ==== logic/tiles.mem ====
// One hex colour of 3 bits per line
// 16 lines per image, tile rows top to bottom, columns left to right
0
5
2
7
3
0
5
2
6
3
0
5
1
6
3
0
1
6
3
0
4
1
6
3
7
4
1
6
2
7
4
1
2
7
4
1
5
2
7
4
0
5
2
7
3
0
5
2
3
0
5
2
6
3
0
5
1
6
3
0
4
1
6
3
4
1
6
3
7
4
1
6
2
7
4
1
5
2
7
4

// ==== logic/titleScreenTop.sv ====
`include "screenDraw_cfg.svh"

module titleScreenTop (
	input  logic clk,
	input  logic reset,
	input  logic userCont,
	input  logic plotReady,
	output logic plot,
	output logic [`X_BITS-1:0] plotX,
	output logic [`Y_BITS-1:0] plotY,
	output logic [`COLOUR_BITS-1:0] plotColour
);

	// Sequencer to scanner and ticker
	logic scanStart;

	// Scanner back to sequencer
	logic scanDone;

	// Ticker to sequencer
	logic frameDue;

	// Image choice for the ROM
	screenPkg::imageT imageSel;

	// Current raster position
	screenPkg::pixelAddrT pixelAddr;

	// Orders the screens
	screenSequencer seq0 (
		.clk(clk),
		.reset(reset),
		.userCont(userCont),
		.scanDone(scanDone),
		.frameDue(frameDue),
		.scanStart(scanStart),
		.imageSel(imageSel)
	);

	// Times the gap between screen starts
	frameTicker ticker0 (
		.clk(clk),
		.reset(reset),
		.scanStart(scanStart),
		.frameDue(frameDue)
	);

	// Walks the screen and hands pixels out
	pixelScanner scan0 (
		.clk(clk),
		.reset(reset),
		.scanStart(scanStart),
		.plotReady(plotReady),
		.plot(plot),
		.pixelAddr(pixelAddr),
		.scanDone(scanDone)
	);

	// Colour lookup, straight to the output
	tileRom rom0 (
		.imageSel(imageSel),
		.pixelAddr(pixelAddr),
		.colour(plotColour)
	);

	// Coordinates out to the VGA adapter
	assign plotX = pixelAddr.coord.x;
	assign plotY = pixelAddr.coord.y;

endmodule

// ==== scanner/pixelScanner.sv ====
`include "screenDraw_cfg.svh"

module pixelScanner (
	input  logic clk,
	input  logic reset,
	input  logic scanStart,
	input  logic plotReady,
	output logic plot,
	output screenPkg::pixelAddrT pixelAddr,
	output logic scanDone
);

	// Last column and row of the screen
	localparam logic [`X_BITS-1:0] xLast = `X_BITS'(`SCREEN_W - 1);
	localparam logic [`Y_BITS-1:0] yLast = `Y_BITS'(`SCREEN_H - 1);

	// Bottom right pixel as one flat word
	localparam logic [`Y_BITS+`X_BITS-1:0] addrLast = {yLast, xLast};

	// Raster position, x and y counters in one word
	screenPkg::pixelAddrT addr;

	// Set for the whole scan
	logic active;

	// Pixel taken by the adapter this cycle
	logic accept;

	assign accept = active && plotReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr.flat <= '0;
			active <= 1'b0;
			scanDone <= 1'b0;
		end else if (scanStart) begin
			// Restart at the origin, even in mid scan
			addr.flat <= '0;
			active <= 1'b1;
			scanDone <= 1'b0;
		end else begin
			scanDone <= 1'b0;
			// Counters move only on handshake
			if (accept) begin
				if (addr.flat == addrLast) begin
					// Final pixel gone, plot drops as done pulses
					active <= 1'b0;
					scanDone <= 1'b1;
				end else if (addr.coord.x == xLast) begin
					// End of row
					addr.coord.x <= '0;
					addr.coord.y <= addr.coord.y + 1'b1;
				end else begin
					addr.coord.x <= addr.coord.x + 1'b1;
				end
			end
		end
	end

	// Valid while active, address held while stalled
	// Low in the load cycle of an aborted scan, the image has already moved on
	assign plot = active && !scanStart;
	assign pixelAddr = addr;

endmodule

// ==== sequencer/screenSequencer.sv ====
module screenSequencer (
	input  logic clk,
	input  logic reset,
	input  logic userCont,
	input  logic scanDone,
	input  logic frameDue,
	output logic scanStart,
	output screenPkg::imageT imageSel
);

	// Current state and the image being drawn
	screenPkg::seqStateT state;
	screenPkg::seqStateT nextState;
	screenPkg::imageT image;
	screenPkg::imageT nextImage;

	// High while one of the three title screens is up
	logic onTitle;

	// Continue press that actually counts
	logic contJump;

	// Successor of an image when its frame tick comes due
	function automatic screenPkg::imageT advanceImage(input screenPkg::imageT img);
		screenPkg::imageT result;
		case (img)
			screenPkg::title1: result = screenPkg::title2;
			screenPkg::title2: result = screenPkg::title3;
			screenPkg::title3: result = screenPkg::title1;
			// Animation just flips between its two frames
			screenPkg::catDog1: result = screenPkg::catDog2;
			screenPkg::catDog2: result = screenPkg::catDog1;
			default: result = screenPkg::title1;
		endcase
		return result;
	endfunction

	assign onTitle = (image == screenPkg::title1) ||
		(image == screenPkg::title2) ||
		(image == screenPkg::title3);

	// Only honoured in draw or hold, never during the load cycle
	assign contJump = userCont && onTitle && (state != screenPkg::load);

	always_comb begin
		nextState = state;
		nextImage = image;
		case (state)
			screenPkg::load: begin
				// One cycle only, scan starts now
				nextState = screenPkg::draw;
			end
			screenPkg::draw: begin
				if (contJump) begin
					// Abort the scan and restart with the animation
					nextState = screenPkg::load;
					nextImage = screenPkg::catDog1;
				end else if (scanDone) begin
					// Always at least one cycle of hold
					nextState = screenPkg::hold;
				end
			end
			screenPkg::hold: begin
				if (contJump) begin
					nextState = screenPkg::load;
					nextImage = screenPkg::catDog1;
				end else if (frameDue) begin
					nextState = screenPkg::load;
					nextImage = advanceImage(image);
				end
			end
			default: begin
				// Recover through a fresh load
				nextState = screenPkg::load;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// First load right after reset, on title1
			state <= screenPkg::load;
			image <= screenPkg::title1;
		end else begin
			state <= nextState;
			image <= nextImage;
		end
	end

	// Decoded straight from the state
	assign scanStart = (state == screenPkg::load);

	// ROM follows the image register
	assign imageSel = image;

endmodule

// ==== tb/titleScreenTb.sv ====
`include "screenDraw_cfg.svh"

module titleScreenTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 40;
	localparam int driveDelay = 2;
	localparam int tileEdge = 1 << `TILE_BITS;
	localparam int tileCells = tileEdge * tileEdge;
	localparam int romDepth = `IMAGE_COUNT * tileCells;
	localparam int indexBits = $clog2(romDepth);
	// Twelve frame periods, doubled for stalls
	localparam int watchdogCycles = 12 * `FRAME_TICK_CYCLES * 2;

	logic clk;
	logic reset;
	logic userCont;
	logic plotReady;
	logic plot;
	logic [`X_BITS-1:0] plotX;
	logic [`Y_BITS-1:0] plotY;
	logic [`COLOUR_BITS-1:0] plotColour;

	// Own copy of the tile data
	logic [`COLOUR_BITS-1:0] tileData [romDepth];

	// Model of the expected screen and raster position
	screenPkg::imageT expImage;
	logic [`X_BITS-1:0] expX;
	logic [`Y_BITS-1:0] expY;
	logic started = 1'b0;
	logic contPending = 1'b0;
	logic scanComplete = 1'b0;
	logic prevReset = 1'b0;
	logic offerZero = 1'b0;
	logic prevOfferZero = 1'b0;
	logic fullSpeed = 1'b0;
	int cycleCount;
	int lastOfferCycle;
	int screenCount;
	int totalScreens;
	int pixelsInScreen;
	int mismatchCount;
	int failCount;
	int unsigned seedValue;

	titleScreenTop dut0 (
		.clk(clk),
		.reset(reset),
		.userCont(userCont),
		.plotReady(plotReady),
		.plot(plot),
		.plotX(plotX),
		.plotY(plotY),
		.plotColour(plotColour)
	);

	bind titleScreenTop titleScreenAssertions chk0 (
		.clk(clk),
		.reset(reset),
		.userCont(userCont),
		.plot(plot),
		.plotReady(plotReady),
		.plotColour(plotColour),
		.pixelAddr(pixelAddr),
		.scanStart(scanStart),
		.scanDone(scanDone)
	);

	// Colour of a pixel, tile repeated over the screen
	function automatic logic [`COLOUR_BITS-1:0] refColour(input screenPkg::imageT img,
		input logic [`X_BITS-1:0] x, input logic [`Y_BITS-1:0] y);
		logic [indexBits-1:0] idx;
		idx = indexBits'(int'(img) * tileCells + (int'(y) % tileEdge) * tileEdge +
			(int'(x) % tileEdge));
		return tileData[idx];
	endfunction

	// Image shown after a frame tick
	function automatic screenPkg::imageT successorImage(input screenPkg::imageT img);
		case (img)
			screenPkg::title1: return screenPkg::title2;
			screenPkg::title2: return screenPkg::title3;
			screenPkg::title3: return screenPkg::title1;
			screenPkg::catDog1: return screenPkg::catDog2;
			screenPkg::catDog2: return screenPkg::catDog1;
			default: return screenPkg::title1;
		endcase
	endfunction

	function automatic logic isTitle(input screenPkg::imageT img);
		return (img == screenPkg::title1) || (img == screenPkg::title2) ||
			(img == screenPkg::title3);
	endfunction

	task automatic compareValue(input string name, input int expected, input int actual);
		if (actual != expected) begin
			mismatchCount++;
			$display("Mismatch at %0d ns: %s expected %0d, got %0d",
				$time, name, expected, actual);
		end
	endtask

	task automatic reportFailure(input string text);
		failCount++;
		$display("Error at %0d ns: %s", $time, text);
	endtask

	// New screen on acceptance of the origin
	task automatic startScreen();
		if (!started) begin
			expImage = screenPkg::title1;
		end else if (contPending) begin
			expImage = screenPkg::catDog1;
		end else begin
			if (!scanComplete) begin
				reportFailure("screen restarted before the previous scan finished");
			end
			expImage = successorImage(expImage);
		end
		started = 1'b1;
		contPending = 1'b0;
		scanComplete = 1'b0;
		expX = '0;
		expY = '0;
		pixelsInScreen = 0;
		screenCount++;
		totalScreens++;
	endtask

	task automatic checkPixel();
		compareValue("plotX", int'(expX), int'(plotX));
		compareValue("plotY", int'(expY), int'(plotY));
		compareValue("plotColour", int'(refColour(expImage, expX, expY)), int'(plotColour));
		pixelsInScreen++;
		// Raster order, row by row
		if (expX == `X_BITS'(`SCREEN_W - 1)) begin
			expX = '0;
			if (expY == `Y_BITS'(`SCREEN_H - 1)) begin
				expY = '0;
				scanComplete = 1'b1;
			end else begin
				expY = expY + 1'b1;
			end
		end else begin
			expX = expX + 1'b1;
		end
	endtask

	initial begin
		$readmemh("logic/tiles.mem", tileData);
	end

	initial begin
		clk = 1'b0;
		forever begin
			#(clkPeriod / 2) clk = ~clk;
		end
	end

	// Random back-pressure, or none in the second run
	initial begin
		plotReady = 1'b0;
		forever begin
			@(posedge clk);
			#(driveDelay);
			plotReady = fullSpeed ? 1'b1 : (($urandom % 4) != 0);
		end
	end

	// Everything sampled mid-cycle, where outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			if (prevReset && plot) begin
				reportFailure("plot is high during reset");
			end
			started = 1'b0;
			contPending = 1'b0;
			scanComplete = 1'b0;
			prevOfferZero = 1'b0;
			screenCount = 0;
			pixelsInScreen = 0;
			cycleCount = 0;
			lastOfferCycle = 0;
		end else begin
			if (prevReset && plot) begin
				reportFailure("plot is high in the load cycle after reset");
			end
			cycleCount++;
			// First cycle the origin is offered marks the screen start
			offerZero = plot && (plotX == '0) && (plotY == '0);
			if (offerZero && !prevOfferZero) begin
				if (started && !contPending &&
					(cycleCount - lastOfferCycle) < `FRAME_TICK_CYCLES) begin
					reportFailure("new screen started before the frame tick came due");
				end
				lastOfferCycle = cycleCount;
			end
			prevOfferZero = offerZero;
			if (plot && plotReady) begin
				if (plotX == '0 && plotY == '0) begin
					startScreen();
				end
				if (!started) begin
					reportFailure("pixel accepted before any screen started");
				end else begin
					checkPixel();
				end
			end
			// Press only counts on a title screen
			if (userCont && started && isTitle(expImage)) begin
				contPending = 1'b1;
			end
		end
		prevReset = reset;
	end

	task automatic applyReset();
		#(driveDelay);
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;
	endtask

	task automatic pressContinue();
		#(driveDelay);
		userCont = 1'b1;
		@(posedge clk);
		#(driveDelay);
		userCont = 1'b0;
	endtask

	task automatic waitScreens(input int count);
		while (screenCount < count) @(posedge clk);
	endtask

	task automatic waitPixels(input int count);
		while (pixelsInScreen < count) @(posedge clk);
	endtask

	task automatic waitScanEnd();
		while (!scanComplete) @(posedge clk);
	endtask

	initial begin
		reset = 1'b1;
		userCont = 1'b0;
		seedValue = $urandom(32'ha86f);
		applyReset();
		// Titles cycle alone, then a press aborts the fourth scan
		waitScreens(4);
		waitPixels(500);
		pressContinue();
		waitScreens(7);
		waitScanEnd();
		// No stalls now, so the scan ends well before the tick
		fullSpeed = 1'b1;
		applyReset();
		waitScreens(1);
		waitScanEnd();
		// Press lands in hold of title1
		repeat (10) @(posedge clk);
		pressContinue();
		waitScreens(3);
		waitScanEnd();
		$display("Run complete: %0d screens, %0d mismatches, %0d other errors",
			totalScreens, mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Timeout: run did not finish within %0d cycles", watchdogCycles);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== tb/titleScreen_assertions.sv ====
`include "screenDraw_cfg.svh"

module titleScreenAssertions (
	input logic clk,
	input logic reset,
	input logic userCont,
	input logic plot,
	input logic plotReady,
	input logic [`COLOUR_BITS-1:0] plotColour,
	input screenPkg::pixelAddrT pixelAddr,
	input logic scanStart,
	input logic scanDone
);

	timeunit 1ns;
	timeprecision 1ps;

	// Stalled pixel keeps address and colour
	// A continue press or a load may restart the scan
	stallHold: assert property (@(posedge clk) disable iff (reset)
		(plot && !plotReady && !userCont && !scanStart) |=>
		(plot && $stable(pixelAddr.flat) && $stable(plotColour)))
		else $error("stalled pixel changed before it was accepted");

	// Load lasts one cycle only
	startPulse: assert property (@(posedge clk) disable iff (reset)
		scanStart |=> !scanStart)
		else $error("scanStart high for more than one cycle");

	donePulse: assert property (@(posedge clk) disable iff (reset)
		scanDone |=> !scanDone)
		else $error("scanDone high for more than one cycle");

	// Valid already low when the scan reports done
	doneEndsPlot: assert property (@(posedge clk) disable iff (reset)
		scanDone |-> !plot)
		else $error("plot still high while scanDone pulses");

	// Every scan opens at the origin
	startAtOrigin: assert property (@(posedge clk) disable iff (reset)
		scanStart |=> (plot && pixelAddr.flat == '0))
		else $error("scan did not begin at the origin");

endmodule
